// File: arm_lite_core.f
+incdir+src
src/core_pkg.sv
src/fetch_queue.sv
src/register_file.sv
src/decode_reg_r.sv
src/hazard_unit.sv
src/execute_reg_r.sv
src/memory_reg_r.sv
src/arm_lite_core.sv
test/arm_lite_core_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
	  --top-module arm_lite_core_tb -f arm_lite_core.f -Mdir obj_dir
	@out="$$(./obj_dir/Varm_lite_core_tb)"; echo "$$out"; \
	  echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// File: test/arm_lite_core_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_settings.svh"

module arm_lite_core_tb;
  import core_pkg::*;

  localparam int DEPTH    = `CORE_QUEUE_DEPTH;
  localparam int MAX_EXP  = 64;
  localparam int WAIT_MAX = 200; // Cycles per wait loop.

  logic      clk_i;
  logic      reset_i;
  logic      flush_i;
  logic      inst_valid_i;
  word_t     inst_i;
  logic      credit_o;
  logic      wb_en_o;
  reg_addr_t wb_addr_o;
  word_t     wb_data_o;

  // Reference model state.
  word_t     ref_regs [16];
  word_t     ref_mem [`CORE_DMEM_WORDS];

  // Expected write-backs in program order.
  reg_addr_t exp_addr [MAX_EXP];
  word_t     exp_data [MAX_EXP];
  string     exp_test [MAX_EXP];
  int        exp_count;
  int        wb_count  = 0;
  int        wb_errors = 0;

  int        returned = 0; // Credit pulses seen.
  int        spent;
  int        credit_base;
  int        check_errors;
  int        seed;
  string     test_name;

  arm_lite_core dut_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .flush_i      (flush_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .credit_o     (credit_o),
    .wb_en_o      (wb_en_o),
    .wb_addr_o    (wb_addr_o),
    .wb_data_o    (wb_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    if (!reset_i && credit_o === 1'b1) begin
      returned++;
    end
  end

  // Write-back collector.
  always @(posedge clk_i) begin
    if (!reset_i && wb_en_o === 1'b1) begin
      if (wb_count >= exp_count) begin
        $display("Unexpected write-back of %h to r%0d", wb_data_o, wb_addr_o);
        wb_errors++;
      end else begin
        if (wb_addr_o !== exp_addr[wb_count] || wb_data_o !== exp_data[wb_count]) begin
          $display("ERR %s: expected r%0d=%h, actual r%0d=%h", exp_test[wb_count],
                   exp_addr[wb_count], exp_data[wb_count], wb_addr_o, wb_data_o);
          wb_errors++;
        end
        wb_count++;
      end
    end
  end

  function automatic int credits_avail();
    return DEPTH - spent + (returned - credit_base);
  endfunction

  function automatic word_t enc_dp_reg(input opcode_t op, input reg_addr_t rd,
                                       input reg_addr_t rn, input reg_addr_t rm);
    return {4'he, 3'b000, op, 1'b0, rn, rd, 8'h00, rm};
  endfunction

  function automatic word_t enc_dp_imm(input opcode_t op, input reg_addr_t rd,
                                       input reg_addr_t rn, input logic [7:0] imm);
    return {4'he, 3'b001, op, 1'b0, rn, rd, 4'h0, imm};
  endfunction

  // Pre-indexed, up, word. Bit 20 picks LDR.
  function automatic word_t enc_mem(input logic load, input reg_addr_t rd,
                                    input reg_addr_t rn, input logic [11:0] imm);
    return {4'he, 3'b010, 4'b1100, load, rn, rd, imm};
  endfunction

  function automatic word_t alu_ref(input opcode_t op, input word_t a, input word_t b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_ORR:  return a | b;
      default: return b; // MOV.
    endcase
  endfunction

  task automatic print_counts();
    $display("Errors: %0d check, %0d write-back; write-backs seen %0d of %0d",
             check_errors, wb_errors, wb_count, exp_count);
  endtask

  task automatic fail_timeout(input string what);
    $display("Timeout in test %s while waiting for %s", test_name, what);
    print_counts();
    $display("Simulation failed");
    $finish;
  endtask

  task automatic send_inst(input word_t word);
    int waited;
    waited = 0;
    while (credits_avail() == 0) begin
      inst_valid_i = 1'b0;
      @(negedge clk_i);
      waited++;
      if (waited > WAIT_MAX) begin
        fail_timeout("a credit");
      end
    end
    inst_i       = word;
    inst_valid_i = 1'b1;
    spent++;
    @(negedge clk_i);
    inst_valid_i = 1'b0;
  endtask

  task automatic expect_wb(input reg_addr_t rd, input word_t data);
    exp_addr[exp_count] = rd;
    exp_data[exp_count] = data;
    exp_test[exp_count] = test_name;
    exp_count++;
    ref_regs[rd] = data;
  endtask

  task automatic dp_reg(input opcode_t op, input reg_addr_t rd,
                        input reg_addr_t rn, input reg_addr_t rm);
    expect_wb(rd, alu_ref(op, ref_regs[rn], ref_regs[rm]));
    send_inst(enc_dp_reg(op, rd, rn, rm));
  endtask

  task automatic dp_imm(input opcode_t op, input reg_addr_t rd,
                        input reg_addr_t rn, input logic [7:0] imm);
    expect_wb(rd, alu_ref(op, ref_regs[rn], {24'd0, imm}));
    send_inst(enc_dp_imm(op, rd, rn, imm));
  endtask

  task automatic mem_op(input logic load, input reg_addr_t rd,
                        input reg_addr_t rn, input logic [11:0] imm);
    word_t addr;
    int    idx;
    addr = ref_regs[rn] + {20'd0, imm};
    idx  = int'((addr >> 2) % `CORE_DMEM_WORDS); // Word address, wrapped.
    if (load) begin
      expect_wb(rd, ref_mem[idx]);
    end else begin
      ref_mem[idx] = ref_regs[rd]; // Stores write nothing back.
    end
    send_inst(enc_mem(load, rd, rn, imm));
  endtask

  // Each credit comes back before its write-back.
  task automatic wait_drained();
    int waited;
    waited = 0;
    while (wb_count < exp_count) begin
      @(negedge clk_i);
      waited++;
      if (waited > WAIT_MAX) begin
        fail_timeout("the pipeline to drain");
      end
    end
  endtask

  task automatic test_credits();
    test_name = "credits";
    if (credit_o !== 1'b0 || wb_en_o !== 1'b0) begin
      $display("ERR %s: expected credit_o=0 wb_en_o=0, actual credit_o=%b wb_en_o=%b",
               test_name, credit_o, wb_en_o);
      check_errors++;
    end
    for (int i = 0; i < DEPTH; i++) begin
      dp_imm(OP_MOV, reg_addr_t'(i + 1), 4'd0, 8'($random(seed)));
    end
    wait_drained();
    if (returned - credit_base != DEPTH) begin
      $display("ERR %s: expected %0d credits returned, actual %0d", test_name, DEPTH,
               returned - credit_base);
      check_errors++;
    end
  endtask

  task automatic test_alu();
    test_name = "alu";
    dp_imm(OP_MOV, 4'd5, 4'd0, 8'($random(seed)));
    dp_imm(OP_MOV, 4'd6, 4'd0, 8'($random(seed)));
    dp_reg(OP_ADD, 4'd7, 4'd5, 4'd6);
    dp_imm(OP_ADD, 4'd8, 4'd6, 8'($random(seed)));
    dp_reg(OP_SUB, 4'd9, 4'd5, 4'd6);
    dp_imm(OP_SUB, 4'd10, 4'd7, 8'($random(seed)));
    dp_reg(OP_AND, 4'd11, 4'd7, 4'd8);
    dp_imm(OP_AND, 4'd12, 4'd9, 8'($random(seed)));
    dp_reg(OP_ORR, 4'd13, 4'd5, 4'd10);
    dp_imm(OP_ORR, 4'd14, 4'd11, 8'($random(seed)));
    wait_drained();
  endtask

  // Each ADD reads the one before it.
  task automatic test_raw_chain();
    test_name = "raw_chain";
    dp_imm(OP_MOV, 4'd2, 4'd0, 8'($random(seed)));
    dp_reg(OP_ADD, 4'd3, 4'd2, 4'd2);
    dp_reg(OP_ADD, 4'd4, 4'd3, 4'd2);
    dp_reg(OP_ADD, 4'd4, 4'd4, 4'd3);
    dp_imm(OP_ADD, 4'd4, 4'd4, 8'($random(seed)));
    dp_reg(OP_ADD, 4'd3, 4'd4, 4'd4);
    wait_drained();
  endtask

  task automatic test_memory();
    int offset;
    test_name = "memory";
    offset    = ($random(seed) & 15) * 4; // Random word offset.
    dp_imm(OP_MOV, 4'd10, 4'd0, 8'($random(seed)));
    dp_imm(OP_MOV, 4'd11, 4'd0, 8'($random(seed)));
    mem_op(1'b0, 4'd11, 4'd10, 12'(offset));
    mem_op(1'b1, 4'd12, 4'd10, 12'(offset));
    dp_imm(OP_ADD, 4'd13, 4'd12, 8'd1);
    wait_drained();
  endtask

  task automatic test_flush();
    int credits_before;
    test_name = "flush";
    // Both still in queue or decode when the flush lands. Values differ from the model.
    send_inst(enc_dp_imm(OP_MOV, 4'd1, 4'd0, ref_regs[1][7:0] ^ 8'h5a));
    send_inst(enc_dp_imm(OP_MOV, 4'd2, 4'd0, ref_regs[2][7:0] ^ 8'h5a));
    flush_i        = 1'b1;
    credits_before = returned;
    @(negedge clk_i);
    flush_i = 1'b0;
    if (returned != credits_before) begin
      $display("ERR %s: expected 0 credits during flush, actual %0d", test_name,
               returned - credits_before);
      check_errors++;
    end
    credit_base = returned; // Source starts over with a full count.
    spent       = 0;
    dp_imm(OP_ADD, 4'd3, 4'd1, 8'd5);
    dp_reg(OP_ORR, 4'd4, 4'd2, 4'd1);
    dp_imm(OP_MOV, 4'd5, 4'd0, 8'($random(seed)));
    dp_reg(OP_SUB, 4'd6, 4'd3, 4'd4);
    wait_drained();
    if (returned - credit_base != DEPTH) begin
      $display("ERR %s: expected %0d credits returned, actual %0d", test_name, DEPTH,
               returned - credit_base);
      check_errors++;
    end
  endtask

  initial begin
    seed         = 32'hd5fe;
    reset_i      = 1'b1;
    flush_i      = 1'b0;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    exp_count    = 0;
    spent        = 0;
    credit_base  = 0;
    check_errors = 0;
    test_name    = "reset";
    repeat (16) @(negedge clk_i);
    reset_i = 1'b0;

    test_credits();
    test_alu();
    test_raw_chain();
    test_memory();
    test_flush();

    repeat (8) @(negedge clk_i); // Quiet time to catch stray write-backs.
    print_counts();
    if (check_errors == 0 && wb_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/arm_lite_core.sv
`timescale 1ns/1ns
`default_nettype none

module arm_lite_core (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                flush_i,
  input  logic                inst_valid_i,
  input  core_pkg::word_t     inst_i,
  output logic                credit_o,
  output logic                wb_en_o,
  output core_pkg::reg_addr_t wb_addr_o,
  output core_pkg::word_t     wb_data_o
);
  import core_pkg::*;

  word_t        head_word;
  logic         head_valid;
  logic         stall;
  logic         dec_valid;
  word_t        dec_inst;
  word_t        dec_r1;
  word_t        dec_r2;
  reg_addr_t    dec_r1_addr;
  reg_addr_t    dec_r2_addr;
  reg_addr_t    dec_rd_addr;
  exec_bundle_t ex_bundle;
  exec_bundle_t mem_bundle;
  wb_bundle_t   wb;

  fetch_queue fetch_queue_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .flush_i      (flush_i),
    .push_i       (inst_valid_i),
    .push_data_i  (inst_i),
    .stall_i      (stall),
    .head_o       (head_word),
    .head_valid_o (head_valid),
    .credit_o     (credit_o)
  );

  decode_reg_r decode_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .inst_i    (head_word),
    .valid_i   (head_valid),
    .flush_i   (flush_i),
    .stall_i   (stall),
    .wb_i      (wb),
    .valid_o   (dec_valid),
    .inst_o    (dec_inst),
    .r1_o      (dec_r1),
    .r2_o      (dec_r2),
    .r1_addr_o (dec_r1_addr),
    .r2_addr_o (dec_r2_addr),
    .rd_addr_o (dec_rd_addr)
  );

  hazard_unit hazard_i (
    .dec_valid_i   (dec_valid),
    .dec_r1_addr_i (dec_r1_addr),
    .dec_r2_addr_i (dec_r2_addr),
    .ex_i          (ex_bundle),
    .mem_i         (mem_bundle),
    .stall_o       (stall)
  );

  // Flush stops at execute. Whatever is already in memory completes.
  execute_reg_r execute_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .flush_i   (flush_i),
    .stall_i   (stall),
    .valid_i   (dec_valid),
    .inst_i    (dec_inst),
    .r1_i      (dec_r1),
    .r2_i      (dec_r2),
    .rd_addr_i (dec_rd_addr),
    .ex_o      (ex_bundle)
  );

  memory_reg_r memory_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .ex_i    (ex_bundle),
    .ex_o    (mem_bundle),
    .wb_o    (wb)
  );

  assign wb_en_o   = wb.en;
  assign wb_addr_o = wb.addr;
  assign wb_data_o = wb.data;

endmodule

`default_nettype wire

// File: src/memory_reg_r.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_settings.svh"

module memory_reg_r (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  core_pkg::exec_bundle_t ex_i,
  output core_pkg::exec_bundle_t ex_o,
  output core_pkg::wb_bundle_t   wb_o
);
  import core_pkg::*;

  localparam int DMEM_AW = $clog2(`CORE_DMEM_WORDS);

  word_t              dmem_q [`CORE_DMEM_WORDS];
  logic [DMEM_AW-1:0] word_idx;
  wb_bundle_t         wb_next;

  // Word address, wrapped to the memory size.
  assign word_idx = ex_i.result[DMEM_AW+1:2];

  always_ff @(posedge clk_i) begin
    if (ex_i.valid && ex_i.is_store) begin
      dmem_q[word_idx] <= ex_i.store_data;
    end
  end

  always_comb begin
    wb_next.en   = ex_i.valid && ex_i.writes_reg;
    wb_next.addr = ex_i.rd;
    wb_next.data = ex_i.is_load ? dmem_q[word_idx] : ex_i.result;
  end

  // The registered bundle copy lines up with wb_o for hazard checks.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ex_o.valid <= 1'b0;
      wb_o.en    <= 1'b0;
    end else begin
      ex_o <= ex_i;
      wb_o <= wb_next;
    end
  end

endmodule

`default_nettype wire

// File: src/execute_reg_r.sv
`timescale 1ns/1ns
`default_nettype none

module execute_reg_r (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   flush_i,
  input  logic                   stall_i,
  input  logic                   valid_i,
  input  core_pkg::word_t        inst_i,
  input  core_pkg::word_t        r1_i,
  input  core_pkg::word_t        r2_i,
  input  core_pkg::reg_addr_t    rd_addr_i,
  output core_pkg::exec_bundle_t ex_o
);
  import core_pkg::*;

  localparam logic [2:0] CLASS_DP_REG = 3'b000;
  localparam logic [2:0] CLASS_DP_IMM = 3'b001;
  localparam logic [2:0] CLASS_MEM    = 3'b010;

  logic [2:0]   inst_class;
  opcode_t      opcode;
  logic         is_dp;
  logic         is_mem;
  logic         op_known;
  word_t        operand_b;
  word_t        alu_result;
  word_t        mem_addr;
  exec_bundle_t ex_next;

  assign inst_class = inst_i[27:25];
  assign opcode     = inst_i[24:21];
  assign is_dp      = (inst_class == CLASS_DP_REG) || (inst_class == CLASS_DP_IMM);
  assign is_mem     = (inst_class == CLASS_MEM);

  // Immediate is zero-extended, no rotation.
  assign operand_b = (inst_class == CLASS_DP_IMM) ? {24'd0, inst_i[7:0]} : r1_i;
  assign mem_addr  = r2_i + {20'd0, inst_i[11:0]}; // Rn plus imm12.

  always_comb begin
    op_known = 1'b1;
    case (opcode)
      OP_ADD:  alu_result = r2_i + operand_b;
      OP_SUB:  alu_result = r2_i - operand_b;
      OP_AND:  alu_result = r2_i & operand_b;
      OP_ORR:  alu_result = r2_i | operand_b;
      OP_MOV:  alu_result = operand_b;
      default: begin
        alu_result = '0;
        op_known   = 1'b0; // Unsupported opcode writes nothing.
      end
    endcase
  end

  always_comb begin
    ex_next.valid      = valid_i && !stall_i && !flush_i; // Bubble while decode holds.
    ex_next.is_load    = is_mem && inst_i[20];
    ex_next.is_store   = is_mem && !inst_i[20];
    ex_next.writes_reg = (is_dp && op_known) || ex_next.is_load;
    ex_next.rd         = rd_addr_i;
    ex_next.result     = is_dp ? alu_result : mem_addr;
    ex_next.store_data = r1_i;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ex_o.valid <= 1'b0;
    end else begin
      ex_o <= ex_next;
    end
  end

endmodule

`default_nettype wire

// File: src/hazard_unit.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
  input  logic                   dec_valid_i,
  input  core_pkg::reg_addr_t    dec_r1_addr_i,
  input  core_pkg::reg_addr_t    dec_r2_addr_i,
  input  core_pkg::exec_bundle_t ex_i,
  input  core_pkg::exec_bundle_t mem_i,
  output logic                   stall_o
);
  import core_pkg::*;

  // True when a stage will write a register decode is reading.
  // Immediate forms still compare the Rm field.
  function automatic logic writes_source(input exec_bundle_t stage);
    writes_source = stage.valid && stage.writes_reg &&
                    ((stage.rd == dec_r1_addr_i) || (stage.rd == dec_r2_addr_i));
  endfunction

  // No forwarding. Wait until the producer has reached the write port.
  assign stall_o = dec_valid_i && (writes_source(ex_i) || writes_source(mem_i));

endmodule

`default_nettype wire

// File: src/decode_reg_r.sv
`timescale 1ns/1ns
`default_nettype none

module decode_reg_r (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  core_pkg::word_t        inst_i,
  input  logic                   valid_i,
  input  logic                   flush_i,
  input  logic                   stall_i,
  input  core_pkg::wb_bundle_t   wb_i,
  output logic                   valid_o,
  output core_pkg::word_t        inst_o,
  output core_pkg::word_t        r1_o,
  output core_pkg::word_t        r2_o,
  output core_pkg::reg_addr_t    r1_addr_o,
  output core_pkg::reg_addr_t    r2_addr_o,
  output core_pkg::reg_addr_t    rd_addr_o
);
  import core_pkg::*;

  localparam logic [2:0] CLASS_MEM = 3'b010;

  word_t     sel_inst;
  reg_addr_t rn_addr;
  reg_addr_t rm_addr;
  reg_addr_t rd_addr;
  reg_addr_t r1_addr;
  reg_addr_t r2_addr;

  // While stalled, keep reading for the held instruction so that a
  // write-back landing during the stall is picked up.
  assign sel_inst = stall_i ? inst_o : inst_i;

  assign rn_addr = sel_inst[19:16];
  assign rm_addr = sel_inst[3:0];
  assign rd_addr = sel_inst[15:12];

  assign r2_addr = rn_addr;
  assign r1_addr = (sel_inst[27:25] == CLASS_MEM) ? rd_addr : rm_addr; // Rd is STR data.

  register_file rf_i (
    .clk_i     (clk_i),
    .a_addr_i  (r1_addr),
    .b_addr_i  (r2_addr),
    .wr_en_i   (wb_i.en),
    .wr_addr_i (wb_i.addr),
    .data_i    (wb_i.data),
    .a_o       (r1_o),
    .b_o       (r2_o)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_o <= 1'b0;
    end else if (!stall_i) begin
      valid_o <= valid_i;
    end
  end

  // Instruction and addresses. Held under stall.
  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      inst_o    <= inst_i;
      r1_addr_o <= r1_addr;
      r2_addr_o <= r2_addr;
      rd_addr_o <= rd_addr;
    end
  end

endmodule

`default_nettype wire

// File: src/register_file.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_settings.svh"

module register_file (
  input  logic                clk_i,
  input  core_pkg::reg_addr_t a_addr_i,
  input  core_pkg::reg_addr_t b_addr_i,
  input  logic                wr_en_i,
  input  core_pkg::reg_addr_t wr_addr_i,
  input  core_pkg::word_t     data_i,
  output core_pkg::word_t     a_o,
  output core_pkg::word_t     b_o
);
  import core_pkg::*;

  word_t regs_q [`CORE_NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      regs_q[wr_addr_i] <= data_i;
    end
    // Registered reads. A same-cycle write is passed straight through.
    a_o <= (wr_en_i && (wr_addr_i == a_addr_i)) ? data_i : regs_q[a_addr_i];
    b_o <= (wr_en_i && (wr_addr_i == b_addr_i)) ? data_i : regs_q[b_addr_i];
  end

endmodule

`default_nettype wire

// File: src/fetch_queue.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_settings.svh"

module fetch_queue (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            flush_i,
  input  logic            push_i,
  input  core_pkg::word_t push_data_i,
  input  logic            stall_i,
  output core_pkg::word_t head_o,
  output logic            head_valid_o,
  output logic            credit_o
);
  import core_pkg::*;

  localparam int DEPTH = `CORE_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  word_t            mem_q [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  // Wraps explicitly so the depth need not be a power of two.
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    next_ptr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign head_valid_o = (count_q != '0);
  assign head_o       = mem_q[rd_ptr_q];

  // The source only pushes while holding a credit, so no full check.
  assign push = push_i && !flush_i;
  assign pop  = head_valid_o && !stall_i && !flush_i;

  // Entries dropped by a flush give no credit back.
  assign credit_o = pop;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop); // Net occupancy change.
    end
  end

endmodule

`default_nettype wire

// File: src/core_pkg.sv
`default_nettype none

package core_pkg;

  typedef logic [31:0] word_t;     // Data or instruction word.
  typedef logic [3:0]  reg_addr_t; // Register number.
  typedef logic [3:0]  opcode_t;   // Data-processing opcode, bits 24:21.

  // Supported data-processing opcodes.
  localparam opcode_t OP_AND = 4'b0000;
  localparam opcode_t OP_SUB = 4'b0010;
  localparam opcode_t OP_ADD = 4'b0100;
  localparam opcode_t OP_ORR = 4'b1100;
  localparam opcode_t OP_MOV = 4'b1101;

  // Execute to memory stage.
  typedef struct packed {
    logic      valid;
    logic      writes_reg;
    logic      is_load;
    logic      is_store;
    reg_addr_t rd;
    word_t     result;     // ALU value, or address for LDR/STR.
    word_t     store_data;
  } exec_bundle_t;

  // Memory stage to register file and ports.
  typedef struct packed {
    logic      en;
    reg_addr_t addr;
    word_t     data;
  } wb_bundle_t;

endpackage

`default_nettype wire

// File: src/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Fetch queue entries. The source starts with this many credits.
`define CORE_QUEUE_DEPTH 4

// Architectural registers.
`define CORE_NUM_REGS 16

// Data memory size in 32-bit words.
`define CORE_DMEM_WORDS 16

`endif
